/* Makefile */
VERILATOR ?= verilator
TOP       ?= aprTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* acBlocks.sv */
`timescale 1ns/10ps
`default_nettype none

module acBlocks import aprPkg::*; (
  input  wire          clk,
  input  wire          arstN,
  input  wire          blkWr,
  input  acBlockWord_s blkWord,
  input  wire          xrPrevious,
  input  wire          vmaPrevEn,
  input  wire          loadVmaContext,
  output logic [2:0]   curBlock,
  output logic [2:0]   prevBlock,
  output logic [2:0]   xrBlock,
  output logic [2:0]   vmaBlock
);

  logic [2:0] vmaBlockNext;

  // Both AC blocks load together from the host
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      curBlock <= 3'd0;
      prevBlock <= 3'd0;
    end else if (blkWr) begin
      curBlock <= blkWord.curBlock;
      prevBlock <= blkWord.prevBlock;
    end
  end

  // Index registers may come from the previous context
  assign xrBlock = xrPrevious ? prevBlock : curBlock;

  assign vmaBlockNext = vmaPrevEn ? prevBlock : curBlock;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      vmaBlock <= 3'd0;
    end else if (loadVmaContext) begin
      vmaBlock <= vmaBlockNext;
    end
  end

endmodule

`default_nettype wire

/* aprFlags.sv */
`timescale 1ns/10ps
`default_nettype none

module aprFlags import aprPkg::*; (
  input  wire                 clk,
  input  wire                 arstN,
  input  aprEvents_s          events,
  input  flagCmd_s            flagCmd,
  output logic [NumFlags-1:0] flags,
  output logic [NumFlags-1:0] intEn,
  output logic                aprInterrupt,
  output logic                anyErrFlg
);

  logic                sweepBusyQ;
  logic [NumFlags-1:0] evPulse;
  logic [NumFlags-1:0] setMask;
  logic [NumFlags-1:0] clrMask;
  logic [NumFlags-1:0] enMask;
  logic [NumFlags-1:0] disMask;

  always_comb begin
    evPulse = '0;
    evPulse[busErr] = events.busErr;
    evPulse[nxmErr] = events.nxmErr;
    evPulse[ioPageFail] = events.ioPageFail;
    evPulse[mbParErr] = events.mbParErr;
    evPulse[cacheDirParErr] = events.cacheDirParErr;
    evPulse[adrParErr] = events.adrParErr;
    evPulse[pwrFail] = events.pwrFail;
    // Sweep finished on the falling edge of busy
    evPulse[sweepDone] = sweepBusyQ & ~events.sweepBusy;
  end

  assign setMask = (flagCmd.conoWr & flagCmd.selSet) ? flagCmd.flagMask : '0;
  assign clrMask = (flagCmd.conoWr & flagCmd.selClr) ? flagCmd.flagMask : '0;
  assign enMask = (flagCmd.conoWr & flagCmd.selEn) ? flagCmd.flagMask : '0;
  assign disMask = (flagCmd.conoWr & flagCmd.selDis) ? flagCmd.flagMask : '0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sweepBusyQ <= 1'b0;
      flags <= '0;
      intEn <= '0;
      anyErrFlg <= 1'b0;
    end else begin
      sweepBusyQ <= events.sweepBusy;
      // Event wins over a clear in the same cycle
      flags <= (flags & ~clrMask) | setMask | evPulse;
      intEn <= (intEn & ~disMask) | enMask;
      anyErrFlg <= flags[nxmErr] | flags[mbParErr] | flags[adrParErr];
    end
  end

  assign aprInterrupt = |(flags & intEn);

  // Clear without set or competing event leaves the masked flags low
  assert property (@(posedge clk) disable iff (!arstN)
    (flagCmd.conoWr && flagCmd.selClr && !flagCmd.selSet &&
     (evPulse & flagCmd.flagMask) == '0)
    |=> (flags & $past(flagCmd.flagMask)) == '0);

endmodule

`default_nettype wire

/* aprPkg.sv */
`default_nettype none

package aprPkg;

  localparam int NumFlags = 8;
  localparam int WbDataW = 16;

  // Flag bit positions in the status word
  typedef enum logic [2:0] {
    busErr         = 3'd0,
    nxmErr         = 3'd1,
    ioPageFail     = 3'd2,
    mbParErr       = 3'd3,
    cacheDirParErr = 3'd4,
    adrParErr      = 3'd5,
    pwrFail        = 3'd6,
    sweepDone      = 3'd7
  } aprFlagIdx;

  // Event pulses, busErr in bit 0
  typedef struct packed {
    logic sweepBusy;
    logic pwrFail;
    logic adrParErr;
    logic cacheDirParErr;
    logic mbParErr;
    logic ioPageFail;
    logic nxmErr;
    logic busErr;
  } aprEvents_s;

  typedef struct packed {
    logic selEn;
    logic selDis;
    logic selSet;
    logic selClr;
    logic [NumFlags-1:0] flagMask;
    logic [3:0] spare;
  } aprConoWord_s;

  typedef struct packed {
    logic [2:0] curBlock;
    logic [2:0] prevBlock;
    logic [9:0] spare;
  } acBlockWord_s;

  // Host write word, meaning depends on register address
  typedef union packed {
    aprConoWord_s cono;
    acBlockWord_s blk;
  } aprCtlWord_u;

  typedef enum logic [2:0] {
    srcAc      = 3'd0,
    srcAcPlus1 = 3'd1,
    srcXr      = 3'd2,
    srcVma     = 3'd3,
    srcAcPlus2 = 3'd4,
    srcAcPlus3 = 3'd5,
    srcAcMagic = 3'd6,
    srcMagic   = 3'd7
  } fmAdrSrc_e;

  typedef struct packed {
    fmAdrSrc_e fmSel;
    logic [8:0] magic;
  } aprUword_s;

  typedef struct packed {
    logic [2:0] block;
    logic [3:0] adr;
  } fmAddr_s;

  typedef struct packed {
    logic conoWr;
    logic selEn;
    logic selDis;
    logic selSet;
    logic selClr;
    logic [NumFlags-1:0] flagMask;
  } flagCmd_s;

endpackage

`default_nettype wire

/* aprTb.sv */
`timescale 1ns/10ps
`default_nettype none

module aprTb import aprPkg::*; ();

  localparam int ClkPeriod = 100;
  localparam int TestCycles = 350;
  localparam int AckLimit = 16;

  logic               clk;
  logic               arstN;
  logic               wbCyc;
  logic               wbStb;
  logic               wbWe;
  logic [2:0]         wbAdr;
  aprCtlWord_u        wbDatW;
  logic [WbDataW-1:0] wbDatR;
  logic               wbAck;
  aprEvents_s         events;
  aprUword_s          uword;
  logic [3:0]         irAc;
  logic [3:0]         xr;
  logic [3:0]         vmaLow;
  logic               xrPrevious;
  logic               vmaPrevEn;
  logic               loadVmaContext;
  logic               aprInterrupt;
  logic               anyErrFlg;
  fmAddr_s            fmAddr;

  int                  seed;
  int                  checks;
  int                  errors;
  logic [NumFlags-1:0] expFlags;
  logic [NumFlags-1:0] expIntEn;
  logic [2:0]          expCur;
  logic [2:0]          expPrev;
  logic [2:0]          expVma;

  aprTop u_dut (
    .clk            (clk),
    .arstN          (arstN),
    .wbCyc          (wbCyc),
    .wbStb          (wbStb),
    .wbWe           (wbWe),
    .wbAdr          (wbAdr),
    .wbDatW         (wbDatW),
    .wbDatR         (wbDatR),
    .wbAck          (wbAck),
    .events         (events),
    .uword          (uword),
    .irAc           (irAc),
    .xr             (xr),
    .vmaLow         (vmaLow),
    .xrPrevious     (xrPrevious),
    .vmaPrevEn      (vmaPrevEn),
    .loadVmaContext (loadVmaContext),
    .aprInterrupt   (aprInterrupt),
    .anyErrFlg      (anyErrFlg),
    .fmAddr         (fmAddr)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(TestCycles * ClkPeriod * 2);
    $display("Watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  task automatic checkWord(input string what, input logic [WbDataW-1:0] got,
                           input logic [WbDataW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkFmAddr(input fmAddr_s got, input fmAddr_s exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: fmAddr block %0d adr %0d, expected block %0d adr %0d",
               $time, got.block, got.adr, exp.block, exp.adr);
    end
  endtask

  function automatic aprCtlWord_u conoWord(input logic en, input logic dis, input logic set,
                                           input logic clr, input logic [NumFlags-1:0] mask);
    aprCtlWord_u w;
    w = '0;
    w.cono.selEn = en;
    w.cono.selDis = dis;
    w.cono.selSet = set;
    w.cono.selClr = clr;
    w.cono.flagMask = mask;
    return w;
  endfunction

  function automatic aprCtlWord_u blockWord(input logic [2:0] cur, input logic [2:0] prev);
    aprCtlWord_u w;
    w = '0;
    w.blk.curBlock = cur;
    w.blk.prevBlock = prev;
    return w;
  endfunction

  function automatic logic [2:0] xrBlockExp();
    return xrPrevious ? expPrev : expCur;
  endfunction

  // Selection rule for the fast-memory address
  function automatic fmAddr_s fmAddrExpected(input fmAdrSrc_e sel, input logic [8:0] magic,
                                             input logic [3:0] ac, input logic [3:0] x,
                                             input logic [3:0] vl);
    fmAddr_s f;
    f.block = expCur;
    f.adr = ac;
    case (sel)
      srcAcPlus1: f.adr = ac + 4'd1;
      srcAcPlus2: f.adr = ac + 4'd2;
      srcAcPlus3: f.adr = ac + 4'd3;
      srcAcMagic: f.adr = ac + magic[3:0];
      srcXr: begin
        f.block = xrBlockExp();
        f.adr = x;
      end
      srcVma: begin
        f.block = expVma;
        f.adr = vl;
      end
      srcMagic: begin
        f.block = magic[6:4];
        f.adr = magic[3:0];
      end
      default: f.adr = ac;
    endcase
    return f;
  endfunction

  // One bus access; ev pulses in the cycle the request is accepted
  task automatic busCycle(input logic we, input logic [2:0] adr, input aprCtlWord_u dat,
                          input aprEvents_s ev, output logic [WbDataW-1:0] rdata);
    int waitCycles;
    waitCycles = 0;
    rdata = '0;
    @(posedge clk);
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe <= we;
    wbAdr <= adr;
    wbDatW <= dat;
    events <= ev;
    @(posedge clk);
    events <= '0;
    @(negedge clk);
    while (!wbAck && waitCycles < AckLimit) begin
      waitCycles++;
      @(negedge clk);
    end
    if (wbAck) begin
      rdata = wbDatR;
    end else begin
      errors++;
      $display("No acknowledge from the register port at address %0d", adr);
    end
    @(posedge clk);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe <= 1'b0;
    @(negedge clk);
    // Ack lasts a single cycle
    checkBit("wbAck after one cycle", wbAck, 1'b0);
  endtask

  task automatic wbWrite(input logic [2:0] adr, input aprCtlWord_u dat);
    logic [WbDataW-1:0] unused;
    busCycle(1'b1, adr, dat, '0, unused);
  endtask

  task automatic wbRead(input logic [2:0] adr, output logic [WbDataW-1:0] data);
    busCycle(1'b0, adr, '0, '0, data);
  endtask

  task automatic pulseEvent(input aprEvents_s ev);
    @(posedge clk);
    events <= ev;
    @(posedge clk);
    events <= '0;
  endtask

  task automatic checkStatus(input string what);
    logic [WbDataW-1:0] d;
    wbRead(3'd0, d);
    checkWord(what, d, {expIntEn, expFlags});
    @(negedge clk);
    checkBit("aprInterrupt", aprInterrupt, |(expFlags & expIntEn));
    checkBit("anyErrFlg", anyErrFlg,
             expFlags[nxmErr] | expFlags[mbParErr] | expFlags[adrParErr]);
  endtask

  task automatic clearAll();
    wbWrite(3'd0, conoWord(1'b0, 1'b1, 1'b0, 1'b1, 8'hff));
    expFlags = '0;
    expIntEn = '0;
  endtask

  task automatic resetValues();
    logic [WbDataW-1:0] d;
    for (int a = 0; a < 8; a++) begin
      wbRead(3'(a), d);
      checkWord("register after reset", d, '0);
    end
    checkBit("aprInterrupt after reset", aprInterrupt, 1'b0);
    checkBit("anyErrFlg after reset", anyErrFlg, 1'b0);
  endtask

  task automatic eventFlagRun();
    for (int i = 0; i < 7; i++) begin
      pulseEvent(aprEvents_s'(8'(1 << i)));
      expFlags[i] = 1'b1;
      checkStatus("status after event");
      wbWrite(3'd0, conoWord(1'b1, 1'b0, 1'b0, 1'b0, 8'(1 << i)));
      expIntEn[i] = 1'b1;
      checkStatus("status after enable");
      clearAll();
    end
  endtask

  task automatic softwareSetClear();
    logic [31:0]         r;
    logic [NumFlags-1:0] m;
    logic [WbDataW-1:0]  d;
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      m = r[7:0];
      wbWrite(3'd0, conoWord(1'b0, 1'b0, 1'b1, 1'b0, m));
      expFlags = expFlags | m;
      checkStatus("status after set");
      r = $random(seed);
      m = r[7:0];
      wbWrite(3'd0, conoWord(1'b0, 1'b0, 1'b0, 1'b1, m));
      expFlags = expFlags & ~m;
      checkStatus("status after clear");
    end
    wbWrite(3'd0, conoWord(1'b0, 1'b0, 1'b1, 1'b0, 8'hff));
    expFlags = 8'hff;
    // ioPageFail arrives with a clear of every flag
    busCycle(1'b1, 3'd0, conoWord(1'b0, 1'b0, 1'b0, 1'b1, 8'hff), aprEvents_s'(8'h04), d);
    expFlags = 8'h04;
    checkStatus("event against clear");
    wbWrite(3'd0, conoWord(1'b1, 1'b0, 1'b0, 1'b0, 8'h04));
    expIntEn = 8'h04;
    checkStatus("status after enable");
    wbWrite(3'd0, conoWord(1'b0, 1'b1, 1'b0, 1'b0, 8'h04));
    expIntEn = '0;
    checkStatus("status after disable");
    clearAll();
  endtask

  task automatic sweepFlagRun();
    @(posedge clk);
    events <= aprEvents_s'(8'h80);
    repeat (3) @(posedge clk);
    events <= '0;
    expFlags[sweepDone] = 1'b1;
    checkStatus("status after sweep");
    checkStatus("status with sweep idle");
    wbWrite(3'd0, conoWord(1'b0, 1'b0, 1'b0, 1'b1, 8'h80));
    expFlags[sweepDone] = 1'b0;
    checkStatus("status after sweep flag clear");
  endtask

  task automatic blockRegisters();
    logic [31:0]        r;
    logic [WbDataW-1:0] d;
    for (int k = 0; k < 3; k++) begin
      r = $random(seed);
      expCur = r[2:0];
      expPrev = (r[5:3] == r[2:0]) ? ~r[2:0] : r[5:3];
      wbWrite(3'd1, blockWord(expCur, expPrev));
      wbRead(3'd1, d);
      checkWord("AC blocks", d, {10'd0, expPrev, expCur});
      for (int x = 0; x < 2; x++) begin
        @(posedge clk);
        xrPrevious <= (x == 1);
        wbRead(3'd3, d);
        checkWord("XR and VMA blocks", d, {10'd0, xrBlockExp(), expVma});
      end
      for (int p = 0; p < 2; p++) begin
        @(posedge clk);
        vmaPrevEn <= (p == 1);
        loadVmaContext <= 1'b1;
        @(posedge clk);
        loadVmaContext <= 1'b0;
        expVma = (p == 1) ? expPrev : expCur;
        wbRead(3'd3, d);
        checkWord("VMA context block", d, {10'd0, xrBlockExp(), expVma});
      end
    end
  endtask

  task automatic fmAddrSources();
    logic [31:0]        r;
    logic [WbDataW-1:0] d;
    fmAddr_s            exp;
    for (int s = 0; s < 8; s++) begin
      r = $random(seed);
      @(posedge clk);
      uword.fmSel <= fmAdrSrc_e'(s);
      uword.magic <= r[8:0];
      irAc <= r[12:9];
      xr <= r[16:13];
      vmaLow <= r[20:17];
      @(negedge clk);
      exp = fmAddrExpected(fmAdrSrc_e'(s), r[8:0], r[12:9], r[16:13], r[20:17]);
      checkFmAddr(fmAddr, exp);
      wbRead(3'd2, d);
      checkWord("fmAddr readback", d, {9'd0, exp.block, exp.adr});
    end
  endtask

  initial begin
    seed = 32'h8a78;
    checks = 0;
    errors = 0;
    expFlags = '0;
    expIntEn = '0;
    expCur = '0;
    expPrev = '0;
    expVma = '0;
    arstN = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatW = '0;
    events = '0;
    uword = '0;
    irAc = '0;
    xr = '0;
    vmaLow = '0;
    xrPrevious = 1'b0;
    vmaPrevEn = 1'b0;
    loadVmaContext = 1'b0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    resetValues();
    eventFlagRun();
    softwareSetClear();
    sweepFlagRun();
    blockRegisters();
    fmAddrSources();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* aprTop.sv */
`timescale 1ns/10ps
`default_nettype none

module aprTop import aprPkg::*; (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire                 wbCyc,
  input  wire                 wbStb,
  input  wire                 wbWe,
  input  wire  [2:0]          wbAdr,
  input  aprCtlWord_u         wbDatW,
  output logic [WbDataW-1:0]  wbDatR,
  output logic                wbAck,
  input  aprEvents_s          events,
  input  aprUword_s           uword,
  input  wire  [3:0]          irAc,
  input  wire  [3:0]          xr,
  input  wire  [3:0]          vmaLow,
  input  wire                 xrPrevious,
  input  wire                 vmaPrevEn,
  input  wire                 loadVmaContext,
  output logic                aprInterrupt,
  output logic                anyErrFlg,
  output fmAddr_s             fmAddr
);

  flagCmd_s            flagCmd;
  logic [NumFlags-1:0] flags;
  logic [NumFlags-1:0] intEn;
  logic                blkWr;
  acBlockWord_s        blkWord;
  logic [2:0]          curBlock;
  logic [2:0]          prevBlock;
  logic [2:0]          xrBlock;
  logic [2:0]          vmaBlock;

  aprWbSlave u_wbSlave (
    .clk       (clk),
    .arstN     (arstN),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatW    (wbDatW),
    .flags     (flags),
    .intEn     (intEn),
    .curBlock  (curBlock),
    .prevBlock (prevBlock),
    .xrBlock   (xrBlock),
    .vmaBlock  (vmaBlock),
    .fmAddr    (fmAddr),
    .wbDatR    (wbDatR),
    .wbAck     (wbAck),
    .flagCmd   (flagCmd),
    .blkWr     (blkWr),
    .blkWord   (blkWord)
  );

  aprFlags u_flags (
    .clk          (clk),
    .arstN        (arstN),
    .events       (events),
    .flagCmd      (flagCmd),
    .flags        (flags),
    .intEn        (intEn),
    .aprInterrupt (aprInterrupt),
    .anyErrFlg    (anyErrFlg)
  );

  acBlocks u_blocks (
    .clk            (clk),
    .arstN          (arstN),
    .blkWr          (blkWr),
    .blkWord        (blkWord),
    .xrPrevious     (xrPrevious),
    .vmaPrevEn      (vmaPrevEn),
    .loadVmaContext (loadVmaContext),
    .curBlock       (curBlock),
    .prevBlock      (prevBlock),
    .xrBlock        (xrBlock),
    .vmaBlock       (vmaBlock)
  );

  fmAddrGen u_fmAddr (
    .uword    (uword),
    .irAc     (irAc),
    .xr       (xr),
    .vmaLow   (vmaLow),
    .curBlock (curBlock),
    .xrBlock  (xrBlock),
    .vmaBlock (vmaBlock),
    .fmAddr   (fmAddr)
  );

endmodule

`default_nettype wire

/* aprWbSlave.sv */
`timescale 1ns/10ps
`default_nettype none

module aprWbSlave import aprPkg::*; (
  input  wire                  clk,
  input  wire                  arstN,
  input  wire                  wbCyc,
  input  wire                  wbStb,
  input  wire                  wbWe,
  input  wire  [2:0]           wbAdr,
  input  aprCtlWord_u          wbDatW,
  input  wire  [NumFlags-1:0]  flags,
  input  wire  [NumFlags-1:0]  intEn,
  input  wire  [2:0]           curBlock,
  input  wire  [2:0]           prevBlock,
  input  wire  [2:0]           xrBlock,
  input  wire  [2:0]           vmaBlock,
  input  fmAddr_s              fmAddr,
  output logic [WbDataW-1:0]   wbDatR,
  output logic                 wbAck,
  output flagCmd_s             flagCmd,
  output logic                 blkWr,
  output acBlockWord_s         blkWord
);

  logic               req;
  logic [WbDataW-1:0] rdMux;

  // No second request while ack is out
  assign req = wbCyc & wbStb & ~wbAck;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= req;
    end
  end

  // CONO view of the write word
  always_comb begin
    flagCmd.conoWr = req & wbWe & (wbAdr == 3'd0);
    flagCmd.selEn = wbDatW.cono.selEn;
    flagCmd.selDis = wbDatW.cono.selDis;
    flagCmd.selSet = wbDatW.cono.selSet;
    flagCmd.selClr = wbDatW.cono.selClr;
    flagCmd.flagMask = wbDatW.cono.flagMask;
  end

  // Block load view of the same word
  assign blkWr = req & wbWe & (wbAdr == 3'd1);
  assign blkWord = wbDatW.blk;

  always_comb begin
    case (wbAdr)
      3'd0: rdMux = {intEn, flags};
      3'd1: rdMux = {10'd0, prevBlock, curBlock};
      3'd2: rdMux = {9'd0, fmAddr.block, fmAddr.adr};
      3'd3: rdMux = {10'd0, xrBlock, vmaBlock};
      default: rdMux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wbDatR <= rdMux;
    end
  end

  // Master drops the strobe once acked
  assert property (@(posedge clk) disable iff (!arstN)
    wbAck |=> !wbStb);

endmodule

`default_nettype wire

/* fmAddrGen.sv */
`timescale 1ns/10ps
`default_nettype none

module fmAddrGen import aprPkg::*; (
  input  aprUword_s  uword,
  input  wire  [3:0] irAc,
  input  wire  [3:0] xr,
  input  wire  [3:0] vmaLow,
  input  wire  [2:0] curBlock,
  input  wire  [2:0] xrBlock,
  input  wire  [2:0] vmaBlock,
  output fmAddr_s    fmAddr
);

  logic [3:0] acPlus1;
  logic [3:0] acPlus2;
  logic [3:0] acPlus3;
  logic [3:0] acPlusMagic;

  // All sums wrap within the 16-word block
  assign acPlus1 = irAc + 4'd1;
  assign acPlus2 = irAc + 4'd2;
  assign acPlus3 = irAc + 4'd3;
  assign acPlusMagic = irAc + uword.magic[3:0];

  always_comb begin
    fmAddr.block = curBlock;
    fmAddr.adr = irAc;
    case (uword.fmSel)
      srcAc: begin
        fmAddr.adr = irAc;
      end
      srcAcPlus1: begin
        fmAddr.adr = acPlus1;
      end
      srcXr: begin
        fmAddr.block = xrBlock;
        fmAddr.adr = xr;
      end
      srcVma: begin
        fmAddr.block = vmaBlock;
        fmAddr.adr = vmaLow;
      end
      srcAcPlus2: begin
        fmAddr.adr = acPlus2;
      end
      srcAcPlus3: begin
        fmAddr.adr = acPlus3;
      end
      srcAcMagic: begin
        fmAddr.adr = acPlusMagic;
      end
      srcMagic: begin
        // Direct block and word from the magic field
        fmAddr.block = uword.magic[6:4];
        fmAddr.adr = uword.magic[3:0];
      end
      default: begin
        fmAddr.adr = irAc;
      end
    endcase
  end

  always_comb begin
    assert (!$isunknown(uword.fmSel))
      else $error("fmAddrGen: unknown fast-memory source select");
  end

endmodule

`default_nettype wire

/* list.f */
aprPkg.sv
aprFlags.sv
acBlocks.sv
fmAddrGen.sv
aprWbSlave.sv
aprTop.sv
aprTb.sv
